// ==== dcache_geom_pkg.sv ====
package dcache_geom_pkg;

	// Word width for both data and byte addresses
	localparam int word_w = 32;

	// Address split: tag | index | block offset | byte offset
	localparam int tag_w = 26;
	localparam int idx_w = 3;

	// Cache shape
	localparam int sets = 8;
	localparam int ways = 2;
	localparam int lines = sets * ways;

	typedef logic [word_w-1:0] word_t;

	// Byte address as seen by the cache
	typedef struct packed {
		logic [tag_w-1:0] tag;
		logic [idx_w-1:0] idx;
		logic             blkoff;
		logic [1:0]       bytoff;
	} daddr_t;

	// One line out of all 16, set index on top and way below
	typedef struct packed {
		logic [idx_w-1:0] idx;
		logic             way;
	} line_sel_t;

endpackage

// ==== dcache_bus_pkg.sv ====
package dcache_bus_pkg;

	// Request from the datapath, ren and wen held until hit
	typedef struct packed {
		logic                  ren;
		logic                  wen;
		logic                  halt;
		dcache_geom_pkg::word_t addr;
		dcache_geom_pkg::word_t store;
	} dp_req_t;

	// Response to the datapath, hit and load are combinational
	typedef struct packed {
		logic                  hit;
		logic                  flushed;
		dcache_geom_pkg::word_t load;
	} dp_rsp_t;

	// One word request toward memory
	typedef struct packed {
		logic                  ren;
		logic                  wen;
		dcache_geom_pkg::word_t addr;
		dcache_geom_pkg::word_t store;
	} mem_req_t;

	// Memory reply, a low dwait completes one word
	typedef struct packed {
		logic                  dwait;
		dcache_geom_pkg::word_t load;
	} mem_rsp_t;

	// Controller states
	typedef enum logic [3:0] {
		idle    = 4'd0,
		wb1     = 4'd1,
		wb2     = 4'd2,
		fd1     = 4'd3,
		fd2     = 4'd4,
		dchk    = 4'd5,
		wbd1    = 4'd6,
		wbd2    = 4'd7,
		flushed = 4'd8
	} ctrl_state_t;

	// Where the memory address and store word come from
	typedef enum logic [1:0] {
		fetch  = 2'd0,
		victim = 2'd1,
		flush  = 2'd2
	} mem_src_t;

endpackage

// ==== dcache_array.sv ====
module dcache_array (
	input  logic                                    CLK,
	input  logic                                    nRST,
	input  dcache_geom_pkg::daddr_t                 addr,
	input  dcache_geom_pkg::word_t                  store,
	input  dcache_geom_pkg::word_t                  mem_load,
	input  logic                                    victim_way,
	input  logic                                    hit_wr,
	input  logic                                    match_way,
	input  logic                                    fill_wr,
	input  logic                                    fill_word,
	input  logic                                    clean,
	input  dcache_geom_pkg::line_sel_t              rd_sel,
	output logic [dcache_geom_pkg::ways-1:0][dcache_geom_pkg::tag_w-1:0] set_tags,
	output logic [dcache_geom_pkg::ways-1:0]        set_valid,
	output logic [dcache_geom_pkg::ways-1:0]        set_dirty,
	output dcache_geom_pkg::word_t [3:0]            set_words,
	output logic [dcache_geom_pkg::lines-1:0]       dirty_vec,
	output logic [dcache_geom_pkg::tag_w-1:0]       rd_tag,
	output dcache_geom_pkg::word_t [1:0]            rd_words
);

	// Line storage, tag and data words carry no reset
	logic [dcache_geom_pkg::tag_w-1:0] tags [dcache_geom_pkg::lines];
	dcache_geom_pkg::word_t [1:0]      data [dcache_geom_pkg::lines];
	logic [dcache_geom_pkg::lines-1:0] valid;
	logic [dcache_geom_pkg::lines-1:0] dirty;

	// Line written by a hit and line replaced by a fill
	dcache_geom_pkg::line_sel_t hit_line;
	dcache_geom_pkg::line_sel_t fill_line;

	assign hit_line  = '{idx: addr.idx, way: match_way};
	assign fill_line = '{idx: addr.idx, way: victim_way};

	////////////////////////////////////////////////////////////////////////////
	// Write paths

	// Hit store or fill word from memory
	always_ff @(posedge CLK) begin
		if (hit_wr) begin
			data[hit_line][addr.blkoff] <= store;
		end else if (fill_wr) begin
			data[fill_line][fill_word] <= mem_load;
			// Tag goes in with the second word
			if (fill_word) begin
				tags[fill_line] <= addr.tag;
			end
		end
	end

	// Valid and dirty bits
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid <= '0;
			dirty <= '0;
		end else begin
			if (hit_wr) begin
				dirty[hit_line] <= 1'b1;
			end else if (fill_wr) begin
				// Invalid during word 0, valid once word 1 lands
				valid[fill_line] <= fill_word;
				dirty[fill_line] <= 1'b0;
			end
			// Line just written back by the flush
			if (clean) begin
				dirty[rd_sel] <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read ports

	// Both ways of the addressed set, words ordered {way, offset}
	always_comb begin
		for (int w = 0; w < dcache_geom_pkg::ways; w++) begin
			set_tags[w]        = tags[{addr.idx, w[0]}];
			set_valid[w]       = valid[{addr.idx, w[0]}];
			set_dirty[w]       = dirty[{addr.idx, w[0]}];
			set_words[2*w]     = data[{addr.idx, w[0]}][0];
			set_words[2*w + 1] = data[{addr.idx, w[0]}][1];
		end
	end

	// Write-back side
	assign dirty_vec = dirty;
	assign rd_tag    = tags[rd_sel];
	assign rd_words  = data[rd_sel];

endmodule

// ==== dcache_lookup.sv ====
module dcache_lookup (
	input  dcache_geom_pkg::daddr_t                 addr,
	input  logic [dcache_geom_pkg::ways-1:0][dcache_geom_pkg::tag_w-1:0] set_tags,
	input  logic [dcache_geom_pkg::ways-1:0]        set_valid,
	input  logic [dcache_geom_pkg::ways-1:0]        set_dirty,
	input  dcache_geom_pkg::word_t [3:0]            set_words,
	input  logic                                    victim_way,
	output logic                                    match,
	output logic                                    match_way,
	output logic                                    victim_dirty,
	output dcache_geom_pkg::word_t                  load
);

	// Per-way tag hit
	logic [dcache_geom_pkg::ways-1:0] way_hit;

	always_comb begin
		for (int w = 0; w < dcache_geom_pkg::ways; w++) begin
			// Only a valid line can match
			way_hit[w] = set_valid[w] && (set_tags[w] == addr.tag);
		end
	end

	assign match = |way_hit;

	// A tag lives in at most one way, so way 1 decides
	assign match_way = way_hit[1];

	// Word picked by the block offset
	assign load = set_words[{match_way, addr.blkoff}];

	// A miss must write the LRU line back first when it is dirty
	assign victim_dirty = set_valid[victim_way] && set_dirty[victim_way];

endmodule

// ==== dcache_lru.sv ====
module dcache_lru (
	input  logic                              CLK,
	input  logic                              nRST,
	input  logic [dcache_geom_pkg::idx_w-1:0] idx,
	input  logic                              touch,
	input  logic                              match_way,
	output logic                              victim_way
);

	// One bit per set, it names the least recently used way
	logic [dcache_geom_pkg::sets-1:0] lru;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			lru <= '0;
		end else if (touch) begin
			// The way not just used becomes the victim
			lru[idx] <= ~match_way;
		end
	end

	// Victim of the addressed set
	// stays put through a miss since only hits touch
	assign victim_way = lru[idx];

endmodule

// ==== dcache_mem_port.sv ====
module dcache_mem_port (
	input  dcache_geom_pkg::daddr_t           addr,
	input  dcache_bus_pkg::mem_src_t          mem_src,
	input  logic                              word_sel,
	input  logic                              victim_way,
	input  logic [dcache_geom_pkg::lines-1:0] dirty_vec,
	input  logic [dcache_geom_pkg::tag_w-1:0] rd_tag,
	input  dcache_geom_pkg::word_t [1:0]      rd_words,
	output logic                              some_dirty,
	output dcache_geom_pkg::line_sel_t        rd_sel,
	output dcache_geom_pkg::word_t            mem_addr,
	output dcache_geom_pkg::word_t            mem_store
);

	// Dirty line chosen by the flush scan
	dcache_geom_pkg::line_sel_t scan_sel;

	// Highest-numbered dirty line wins
	always_comb begin
		scan_sel = '0;
		for (int s = 0; s < dcache_geom_pkg::sets; s++) begin
			for (int w = 0; w < dcache_geom_pkg::ways; w++) begin
				if (dirty_vec[s*dcache_geom_pkg::ways + w]) begin
					scan_sel.idx = s[dcache_geom_pkg::idx_w-1:0];
					scan_sel.way = w[0];
				end
			end
		end
	end

	assign some_dirty = |dirty_vec;

	// Address source by kind of transfer
	always_comb begin
		unique case (mem_src)
			dcache_bus_pkg::flush: begin
				rd_sel   = scan_sel;
				mem_addr = {rd_tag, scan_sel.idx, word_sel, 2'b00};
			end
			dcache_bus_pkg::victim: begin
				// Stored tag of the LRU way
				rd_sel   = '{idx: addr.idx, way: victim_way};
				mem_addr = {rd_tag, addr.idx, word_sel, 2'b00};
			end
			default: begin
				// Fetch of the requested line
				rd_sel   = '{idx: addr.idx, way: victim_way};
				mem_addr = {addr.tag, addr.idx, word_sel, 2'b00};
			end
		endcase
	end

	// Store word for any write-back
	assign mem_store = rd_words[word_sel];

endmodule

// ==== dcache_ctrl.sv ====
module dcache_ctrl (
	input  logic                     CLK,
	input  logic                     nRST,
	input  dcache_bus_pkg::dp_req_t  req,
	input  logic                     dwait,
	input  logic                     match,
	input  logic                     victim_dirty,
	input  logic                     some_dirty,
	output logic                     hit,
	output logic                     flushed,
	output logic                     hit_wr,
	output logic                     touch,
	output logic                     fill_wr,
	output logic                     fill_word,
	output logic                     clean,
	output dcache_bus_pkg::mem_src_t mem_src,
	output logic                     word_sel,
	output logic                     mem_ren,
	output logic                     mem_wen
);

	dcache_bus_pkg::ctrl_state_t state;
	dcache_bus_pkg::ctrl_state_t next_state;

	// Word of memory done this cycle
	logic word_done;
	logic access;

	assign word_done = !dwait;
	assign access    = req.ren || req.wen;

	////////////////////////////////////////////////////////////////////////////
	// State register and next state

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= dcache_bus_pkg::idle;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		unique case (state)
			dcache_bus_pkg::idle: begin
				// Halt first, then a miss
				if (req.halt) begin
					next_state = dcache_bus_pkg::dchk;
				end else if (access && !match) begin
					next_state = victim_dirty ? dcache_bus_pkg::wb1 : dcache_bus_pkg::fd1;
				end
			end
			// Victim write-back, two words
			dcache_bus_pkg::wb1: if (word_done) next_state = dcache_bus_pkg::wb2;
			dcache_bus_pkg::wb2: if (word_done) next_state = dcache_bus_pkg::fd1;
			// Line fill, two words
			dcache_bus_pkg::fd1: if (word_done) next_state = dcache_bus_pkg::fd2;
			dcache_bus_pkg::fd2: if (word_done) next_state = dcache_bus_pkg::idle;
			// Flush loop, one dirty line per pass
			dcache_bus_pkg::dchk: begin
				next_state = some_dirty ? dcache_bus_pkg::wbd1 : dcache_bus_pkg::flushed;
			end
			dcache_bus_pkg::wbd1: if (word_done) next_state = dcache_bus_pkg::wbd2;
			dcache_bus_pkg::wbd2: if (word_done) next_state = dcache_bus_pkg::dchk;
			// Held until reset
			dcache_bus_pkg::flushed: next_state = dcache_bus_pkg::flushed;
			default: next_state = dcache_bus_pkg::idle;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Strobes

	// Hit only answered from idle
	assign hit    = (state == dcache_bus_pkg::idle) && access && match;
	assign hit_wr = hit && req.wen;
	assign touch  = hit;

	// Fill words land as memory completes them
	assign fill_wr   = ((state == dcache_bus_pkg::fd1) || (state == dcache_bus_pkg::fd2))
		&& word_done;
	assign fill_word = (state == dcache_bus_pkg::fd2);

	// Dirty bit drops after the second flush word
	assign clean = (state == dcache_bus_pkg::wbd2) && word_done;

	assign flushed = (state == dcache_bus_pkg::flushed);

	// Memory side
	always_comb begin
		mem_src  = dcache_bus_pkg::fetch;
		word_sel = 1'b0;
		mem_ren  = 1'b0;
		mem_wen  = 1'b0;
		unique case (state)
			dcache_bus_pkg::wb1, dcache_bus_pkg::wb2: begin
				mem_src  = dcache_bus_pkg::victim;
				mem_wen  = 1'b1;
				word_sel = (state == dcache_bus_pkg::wb2);
			end
			dcache_bus_pkg::fd1, dcache_bus_pkg::fd2: begin
				mem_ren  = 1'b1;
				word_sel = (state == dcache_bus_pkg::fd2);
			end
			dcache_bus_pkg::wbd1, dcache_bus_pkg::wbd2: begin
				mem_src  = dcache_bus_pkg::flush;
				mem_wen  = 1'b1;
				word_sel = (state == dcache_bus_pkg::wbd2);
			end
			// Scan is already selected while checking
			dcache_bus_pkg::dchk: mem_src = dcache_bus_pkg::flush;
			default: mem_src = dcache_bus_pkg::fetch;
		endcase
	end

endmodule

// ==== dcache_top.sv ====
module dcache_top (
	input  logic                     CLK,
	input  logic                     nRST,
	input  dcache_bus_pkg::dp_req_t  dp_req,
	output dcache_bus_pkg::dp_rsp_t  dp_rsp,
	output dcache_bus_pkg::mem_req_t mem_req,
	input  dcache_bus_pkg::mem_rsp_t mem_rsp
);

	// Request address split into fields
	dcache_geom_pkg::daddr_t addr;

	// Set view from the array
	logic [dcache_geom_pkg::ways-1:0][dcache_geom_pkg::tag_w-1:0] set_tags;
	logic [dcache_geom_pkg::ways-1:0] set_valid;
	logic [dcache_geom_pkg::ways-1:0] set_dirty;
	dcache_geom_pkg::word_t [3:0]     set_words;

	// Write-back view
	logic [dcache_geom_pkg::lines-1:0] dirty_vec;
	logic [dcache_geom_pkg::tag_w-1:0] rd_tag;
	dcache_geom_pkg::word_t [1:0]      rd_words;
	dcache_geom_pkg::line_sel_t        rd_sel;

	// Lookup and LRU
	logic match, match_way, victim_dirty, victim_way;
	dcache_geom_pkg::word_t load;

	// Controller strobes
	logic hit, flushed, hit_wr, touch, fill_wr, fill_word, clean;
	logic word_sel, some_dirty, mem_ren, mem_wen;
	dcache_bus_pkg::mem_src_t mem_src;
	dcache_geom_pkg::word_t   mem_addr, mem_store;

	assign addr = dp_req.addr;

	dcache_array i_array (.CLK, .nRST, .addr, .store(dp_req.store), .mem_load(mem_rsp.load),
		.victim_way, .hit_wr, .match_way, .fill_wr, .fill_word, .clean, .rd_sel,
		.set_tags, .set_valid, .set_dirty, .set_words, .dirty_vec, .rd_tag, .rd_words);

	dcache_lookup i_lookup (.addr, .set_tags, .set_valid, .set_dirty, .set_words,
		.victim_way, .match, .match_way, .victim_dirty, .load);

	dcache_lru i_lru (.CLK, .nRST, .idx(addr.idx), .touch, .match_way, .victim_way);

	dcache_mem_port i_mem_port (.addr, .mem_src, .word_sel, .victim_way, .dirty_vec,
		.rd_tag, .rd_words, .some_dirty, .rd_sel, .mem_addr, .mem_store);

	dcache_ctrl i_ctrl (.CLK, .nRST, .req(dp_req), .dwait(mem_rsp.dwait), .match,
		.victim_dirty, .some_dirty, .hit, .flushed, .hit_wr, .touch, .fill_wr,
		.fill_word, .clean, .mem_src, .word_sel, .mem_ren, .mem_wen);

	// Response and memory structs
	assign dp_rsp  = '{hit: hit, flushed: flushed, load: load};
	assign mem_req = '{ren: mem_ren, wen: mem_wen, addr: mem_addr, store: mem_store};

endmodule

// ==== tb_mem_model.sv ====
module tb_mem_model #(
	parameter dcache_geom_pkg::word_t fill_key = 32'h0
) (
	input  logic                     CLK,
	input  logic                     nRST,
	input  dcache_bus_pkg::mem_req_t mem_req,
	output dcache_bus_pkg::mem_rsp_t mem_rsp,
	output int                       rd_count,
	output int                       wr_count
);
	timeunit 1ns;
	timeprecision 100ps;

	// Sparse word memory where untouched words read as address XOR key
	dcache_geom_pkg::word_t mem [dcache_geom_pkg::word_t];

	logic [31:0]            rand_state;
	int                     lat_left;
	logic                   dwait;
	dcache_geom_pkg::word_t load_word;

	// Current content of the word holding byte address a
	function automatic dcache_geom_pkg::word_t peek(input dcache_geom_pkg::word_t a);
		dcache_geom_pkg::word_t w;
		w = {a[31:2], 2'b00};
		if (mem.exists(w)) begin
			return mem[w];
		end
		return w ^ fill_key;
	endfunction

	// LCG step with the constants of the classic 32-bit generator
	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Handshake with one word per dwait-low cycle

	always @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			dwait      <= 1'b1;
			lat_left   <= -1;
			rd_count   <= 0;
			wr_count   <= 0;
			rand_state <= 32'haea8a4da;
		end else if (!dwait) begin
			// Word completes at this edge
			dwait    <= 1'b1;
			lat_left <= -1;
			if (mem_req.wen) begin
				wr_count <= wr_count + 1;
			end else if (mem_req.ren) begin
				rd_count <= rd_count + 1;
			end
		end else if (mem_req.ren || mem_req.wen) begin
			if (lat_left < 0) begin
				// New word draws a dwait-high time of 1 to 4 cycles
				rand_state <= lcg_step(rand_state);
				if (rand_state[17:16] == 2'd0) begin
					dwait <= 1'b0;
				end else begin
					lat_left <= int'(rand_state[17:16]) - 1;
				end
			end else if (lat_left == 0) begin
				dwait <= 1'b0;
			end else begin
				lat_left <= lat_left - 1;
			end
		end
	end

	// Store lands at the completing edge
	always @(posedge CLK) begin
		if (nRST && !dwait && mem_req.wen) begin
			mem[{mem_req.addr[31:2], 2'b00}] = mem_req.store;
		end
	end

	// Read data only meaningful while dwait is low
	assign load_word = dwait ? '0 : peek(mem_req.addr);
	assign mem_rsp   = '{dwait: dwait, load: load_word};

endmodule

// ==== dcache_sva.sv ====
module dcache_sva (
	input logic                     CLK,
	input logic                     nRST,
	input dcache_bus_pkg::dp_req_t  dp_req,
	input dcache_bus_pkg::dp_rsp_t  dp_rsp,
	input dcache_bus_pkg::mem_req_t mem_req
);
	timeunit 1ns;
	timeprecision 100ps;

	// One kind of memory transfer at a time
	one_mem_op: assert property (@(posedge CLK) disable iff (!nRST)
		!(mem_req.ren && mem_req.wen))
		else $error("memory read and write requested in the same cycle");

	// Flushed cache leaves the bus alone
	quiet_after_flush: assert property (@(posedge CLK) disable iff (!nRST)
		dp_rsp.flushed |-> !(mem_req.ren || mem_req.wen))
		else $error("memory request made while flushed is high");

	// hit only answers a pending access
	hit_needs_req: assert property (@(posedge CLK) disable iff (!nRST)
		dp_rsp.hit |-> (dp_req.ren || dp_req.wen))
		else $error("hit raised without a read or write request");

endmodule

bind dcache_top dcache_sva i_sva (.CLK, .nRST, .dp_req, .dp_rsp, .mem_req);

// ==== tb_dcache.sv ====
module tb_dcache;
	timeunit 1ns;
	timeprecision 100ps;

	localparam dcache_geom_pkg::word_t fill_key = 32'h5ca1ab1e;
	localparam int wait_limit = 200;

	logic                     CLK;
	logic                     nRST;
	dcache_bus_pkg::dp_req_t  dp_req;
	dcache_bus_pkg::dp_rsp_t  dp_rsp;
	dcache_bus_pkg::mem_req_t mem_req;
	dcache_bus_pkg::mem_rsp_t mem_rsp;
	int                       rd_count;
	int                       wr_count;
	int                       errors;
	int                       checks;

	// Last word written per address, and lines left dirty in the cache
	dcache_geom_pkg::word_t stored [dcache_geom_pkg::word_t];
	bit                     dirty_lines [dcache_geom_pkg::word_t];

	dcache_top i_dut (.CLK, .nRST, .dp_req, .dp_rsp, .mem_req, .mem_rsp);

	tb_mem_model #(.fill_key(fill_key)) i_mem (.CLK, .nRST, .mem_req, .mem_rsp,
		.rd_count, .wr_count);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers

	// Byte address from tag, set and word in line
	function automatic dcache_geom_pkg::word_t make_addr(input int tag, input int idx,
		input logic off);
		dcache_geom_pkg::daddr_t a;
		a.tag    = tag[dcache_geom_pkg::tag_w-1:0];
		a.idx    = idx[dcache_geom_pkg::idx_w-1:0];
		a.blkoff = off;
		a.bytoff = 2'b00;
		return a;
	endfunction

	function automatic dcache_geom_pkg::word_t line_of(input dcache_geom_pkg::word_t a);
		return {a[31:3], 3'b000};
	endfunction

	task automatic check_word(input string name, input dcache_geom_pkg::word_t exp,
		input dcache_geom_pkg::word_t got);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, got);
		end
	endtask

	task automatic check_int(input string name, input int exp, input int got);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, got);
		end
	endtask

	// One datapath access, held until hit; waited counts cycles before hit
	task automatic access(input logic wr, input dcache_geom_pkg::word_t addr,
		input dcache_geom_pkg::word_t data, output dcache_geom_pkg::word_t load,
		output int waited);
		@(posedge CLK);
		#1;
		dp_req.ren   = !wr;
		dp_req.wen   = wr;
		dp_req.addr  = addr;
		dp_req.store = data;
		waited       = 0;
		load         = '0;
		// hit is combinational, look mid-cycle
		@(negedge CLK);
		while (!dp_rsp.hit && waited < wait_limit) begin
			@(negedge CLK);
			waited++;
		end
		if (dp_rsp.hit) begin
			load = dp_rsp.load;
			if (wr) begin
				stored[addr]              = data;
				dirty_lines[line_of(addr)] = 1'b1;
			end
		end else begin
			errors++;
			$display("Timeout: no hit for address %h after %0d cycles", addr, waited);
		end
		@(posedge CLK);
		#1;
		dp_req.ren = 1'b0;
		dp_req.wen = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests

	task automatic reset_outputs_low;
		check_int("reset hit", 0, int'(dp_rsp.hit));
		check_int("reset flushed", 0, int'(dp_rsp.flushed));
		check_int("reset mem ren", 0, int'(mem_req.ren));
		check_int("reset mem wen", 0, int'(mem_req.wen));
	endtask

	task automatic read_miss_fill;
		dcache_geom_pkg::word_t a;
		dcache_geom_pkg::word_t b;
		dcache_geom_pkg::word_t got;
		int waited;
		int rd0;
		int wr0;
		a   = make_addr(1, 2, 1'b0);
		b   = make_addr(1, 2, 1'b1);
		rd0 = rd_count;
		wr0 = wr_count;
		access(1'b0, a, '0, got, waited);
		check_word("read_miss load", a ^ fill_key, got);
		check_int("read_miss mem reads", 2, rd_count - rd0);
		check_int("read_miss mem writes", 0, wr_count - wr0);
		// Other word of the line is already present
		rd0 = rd_count;
		access(1'b0, b, '0, got, waited);
		check_word("read_miss neighbor load", b ^ fill_key, got);
		check_int("read_miss neighbor wait", 0, waited);
		check_int("read_miss neighbor mem reads", 0, rd_count - rd0);
	endtask

	task automatic write_hit_readback;
		dcache_geom_pkg::word_t a;
		dcache_geom_pkg::word_t got;
		int waited;
		int rd0;
		int wr0;
		a   = make_addr(1, 2, 1'b0);
		rd0 = rd_count;
		wr0 = wr_count;
		access(1'b1, a, 32'hc0de0001, got, waited);
		check_int("write_hit wait", 0, waited);
		access(1'b0, a, '0, got, waited);
		check_word("write_hit readback", 32'hc0de0001, got);
		check_int("write_hit readback wait", 0, waited);
		check_int("write_hit mem reads", 0, rd_count - rd0);
		check_int("write_hit mem writes", 0, wr_count - wr0);
	endtask

	// A and B fill set 5, A touched last so C must evict dirty B
	task automatic lru_and_writeback;
		dcache_geom_pkg::word_t a;
		dcache_geom_pkg::word_t b;
		dcache_geom_pkg::word_t b0;
		dcache_geom_pkg::word_t c;
		dcache_geom_pkg::word_t got;
		int waited;
		int rd0;
		int wr0;
		a  = make_addr(10, 5, 1'b0);
		b  = make_addr(11, 5, 1'b1);
		b0 = make_addr(11, 5, 1'b0);
		c  = make_addr(12, 5, 1'b0);
		access(1'b1, a, 32'haaaa0010, got, waited);
		access(1'b1, b, 32'hbbbb0011, got, waited);
		access(1'b0, a, '0, got, waited);
		check_word("lru reread A", 32'haaaa0010, got);
		check_int("lru reread A wait", 0, waited);
		rd0 = rd_count;
		wr0 = wr_count;
		access(1'b0, c, '0, got, waited);
		check_word("lru miss C load", c ^ fill_key, got);
		check_int("lru miss C mem reads", 2, rd_count - rd0);
		check_int("lru miss C mem writes", 2, wr_count - wr0);
		check_word("lru victim B stored word", 32'hbbbb0011, i_mem.peek(b));
		check_word("lru victim B other word", b0 ^ fill_key, i_mem.peek(b0));
		dirty_lines.delete(line_of(b));
		// A must have survived the eviction
		rd0 = rd_count;
		access(1'b0, a, '0, got, waited);
		check_word("lru A after eviction", 32'haaaa0010, got);
		check_int("lru A after eviction mem reads", 0, rd_count - rd0);
	endtask

	task automatic halt_flush;
		dcache_geom_pkg::word_t d;
		dcache_geom_pkg::word_t got;
		int waited;
		int wr0;
		int expected;
		d = make_addr(20, 7, 1'b1);
		access(1'b1, d, 32'hdddd0020, got, waited);
		expected = dirty_lines.num();
		wr0      = wr_count;
		@(posedge CLK);
		#1;
		dp_req.halt = 1'b1;
		waited      = 0;
		@(negedge CLK);
		while (!dp_rsp.flushed && waited < wait_limit) begin
			@(negedge CLK);
			waited++;
		end
		if (!dp_rsp.flushed) begin
			errors++;
			$display("Timeout: flushed not raised after %0d cycles of halt", waited);
		end
		check_int("flush mem writes", 2 * expected, wr_count - wr0);
		foreach (stored[k]) begin
			check_word($sformatf("flush memory at %h", k), stored[k], i_mem.peek(k));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Bus watch, mid-cycle

	always @(negedge CLK) begin
		if (nRST) begin
			assert (!(mem_req.ren && mem_req.wen)) else begin
				errors++;
				$display("Bus error: memory read and write requested together");
			end
			assert (!(dp_rsp.flushed && (mem_req.ren || mem_req.wen))) else begin
				errors++;
				$display("Bus error: memory request made after flushed was raised");
			end
		end
	end

	initial begin
		errors = 0;
		checks = 0;
		nRST   = 1'b0;
		dp_req = '0;
		repeat (16) @(posedge CLK);
		#1;
		nRST = 1'b1;
		reset_outputs_low();
		read_miss_fill();
		write_hit_readback();
		lru_and_writeback();
		halt_flush();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// ==== src.f ====
dcache_geom_pkg.sv
dcache_bus_pkg.sv
dcache_array.sv
dcache_lookup.sv
dcache_lru.sv
dcache_mem_port.sv
dcache_ctrl.sv
dcache_top.sv
tb_mem_model.sv
dcache_sva.sv
tb_dcache.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP      = tb_dcache
FILELIST = src.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
